//--- cpu_top.f
+incdir+.
cpu_pkg.sv
mem_req_if.sv
cpu_regfile.sv
cpu_alu.sv
cpu_axi_read_port.sv
cpu_axi_write_port.sv
cpu_control.sv
cpu_top.sv
cpu_checker.sv
tb_clk_gen.sv
tb_cpu_top.sv

//--- Bender.yml
package:
  name: cpu_top

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - mem_req_if.sv
      - cpu_regfile.sv
      - cpu_alu.sv
      - cpu_axi_read_port.sv
      - cpu_axi_write_port.sv
      - cpu_control.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_checker.sv
      - tb_clk_gen.sv
      - tb_cpu_top.sv

//--- tb_cpu_top.sv
// processor testbench
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu_top;

    localparam int PROG_LEN   = 64;
    localparam int RETIRE_N   = 300;
    localparam int MEM_WORDS  = 1 << `CPU_PC_W;

    logic clk;
    logic rst_n;
    logic io_stall_o;
    logic [`CPU_ADDR_W-1:0] awaddr_o;
    logic awvalid_o;
    logic awready_i;
    logic [`CPU_DATA_W-1:0] wdata_o;
    logic wvalid_o;
    logic wready_i;
    logic bvalid_i;
    logic [`CPU_ADDR_W-1:0] araddr_inst_o;
    logic arvalid_inst_o;
    logic arready_inst_i;
    logic rvalid_inst_i;
    logic [`CPU_DATA_W-1:0] rdata_inst_i;
    logic [`CPU_ADDR_W-1:0] araddr_data_o;
    logic arvalid_data_o;
    logic arready_data_i;
    logic rvalid_data_i;
    logic [`CPU_DATA_W-1:0] rdata_data_i;

    integer seed;
    int retired;
    int fetches;
    logic [`CPU_DATA_W-1:0] imem [MEM_WORDS];
    logic [`CPU_DATA_W-1:0] mem_data [MEM_WORDS];
    // reference model state
    logic [`CPU_DATA_W-1:0] model_dmem [MEM_WORDS];
    logic signed [`CPU_DATA_W-1:0] model_regs [`CPU_REG_N];
    logic [`CPU_PC_W-1:0] model_pc;

    tb_clk_gen #(.PERIOD(100), .RST_CYCLES(4)) i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    cpu_top i_cpu_top (.*);

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            abort_run("value check failed");
        end
    endtask

    function automatic int rand_delay();
        return {$random(seed)} % 4;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // ISA reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`CPU_PC_W-1:0] imm_ext(input cpu_pkg::insn_t insn);
        return {{(`CPU_PC_W-5){insn.rd[3]}}, insn.rd, insn.func};
    endfunction

    function automatic logic [`CPU_PC_W-1:0] model_ea(input cpu_pkg::insn_t insn);
        logic [`CPU_DATA_W-1:0] sum;
        sum = model_regs[insn.rs] + {{(`CPU_DATA_W-5){insn.rd[3]}}, insn.rd, insn.func};
        return sum[`CPU_PC_W-1:0];
    endfunction

    function automatic logic [`CPU_ADDR_W-1:0] byte_addr(input logic [`CPU_PC_W-1:0] w);
        return `CPU_MEM_BASE + 2 * w;
    endfunction

    task automatic model_step();
        cpu_pkg::insn_t insn;
        logic signed [`CPU_DATA_W-1:0] a;
        logic signed [`CPU_DATA_W-1:0] b;
        logic signed [2*`CPU_DATA_W-1:0] prod;
        logic [`CPU_PC_W-1:0] ea;
        logic [`CPU_PC_W-1:0] nxt;
        insn = cpu_pkg::insn_t'(imem[model_pc]);
        a    = model_regs[insn.rs];
        b    = model_regs[insn.rt];
        ea   = model_ea(insn);
        nxt  = model_pc + 1'b1;
        case (insn.op)
            cpu_pkg::OP_ARITH: model_regs[insn.rd] = insn.func ? a - b : a + b;
            cpu_pkg::OP_MULSLT: begin
                prod = a * b;
                model_regs[insn.rd] = insn.func ? prod[`CPU_DATA_W-1:0] : ((a < b) ? 1 : 0);
            end
            cpu_pkg::OP_LOAD:  model_regs[insn.rt] = model_dmem[ea];
            cpu_pkg::OP_STORE: model_dmem[ea] = b;
            cpu_pkg::OP_BEQ: begin
                if (a == b) begin
                    nxt = model_pc + 1'b1 + imm_ext(insn);
                end
            end
            cpu_pkg::OP_JUMP: nxt = insn[11:1];
            default: ;
        endcase
        model_pc = nxt;
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory responders
    //////////////////////////////////////////////////////////////////////

    task automatic serve_read(input bit is_inst);
        logic [`CPU_ADDR_W-1:0] addr;
        cpu_pkg::insn_t cur;
        do begin
            @(posedge clk);
            #1;
        end while (is_inst ? !arvalid_inst_o : !arvalid_data_o);
        cur = cpu_pkg::insn_t'(imem[model_pc]);
        if (is_inst) begin
            addr = araddr_inst_o;
            fetches++;
            compare("araddr_inst_o", byte_addr(model_pc), addr);
        end else begin
            addr = araddr_data_o;
            compare("load opcode", cpu_pkg::OP_LOAD, cur.op);
            compare("araddr_data_o", byte_addr(model_ea(cur)), addr);
        end
        repeat (rand_delay()) begin
            @(posedge clk);
            #1;
        end
        if (is_inst) arready_inst_i = 1'b1;
        else arready_data_i = 1'b1;
        @(posedge clk);
        #1;
        arready_inst_i = 1'b0;
        arready_data_i = 1'b0;
        repeat (rand_delay()) begin
            @(posedge clk);
            #1;
        end
        if (is_inst) begin
            rvalid_inst_i = 1'b1;
            rdata_inst_i  = imem[(addr - `CPU_MEM_BASE) >> 1];
        end else begin
            rvalid_data_i = 1'b1;
            rdata_data_i  = mem_data[(addr - `CPU_MEM_BASE) >> 1];
        end
        @(posedge clk);
        #1;
        rvalid_inst_i = 1'b0;
        rvalid_data_i = 1'b0;
    endtask

    task automatic serve_write();
        cpu_pkg::insn_t cur;
        int da;
        int dw;
        int k;
        bit aw_done;
        bit w_done;
        do begin
            @(posedge clk);
            #1;
        end while (!awvalid_o);
        cur = cpu_pkg::insn_t'(imem[model_pc]);
        compare("store opcode", cpu_pkg::OP_STORE, cur.op);
        compare("wvalid_o", 1'b1, wvalid_o);
        compare("awaddr_o", byte_addr(model_ea(cur)), awaddr_o);
        compare("wdata_o", $unsigned(model_regs[cur.rt]), wdata_o);
        mem_data[(awaddr_o - `CPU_MEM_BASE) >> 1] = wdata_o;
        da = rand_delay();
        dw = rand_delay();
        k = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        // AW and W accepted on their own schedules
        while (!(aw_done && w_done)) begin
            awready_i = !aw_done && (k >= da);
            wready_i  = !w_done && (k >= dw);
            @(posedge clk);
            #1;
            if (awready_i) aw_done = 1'b1;
            if (wready_i) w_done = 1'b1;
            k++;
        end
        awready_i = 1'b0;
        wready_i  = 1'b0;
        repeat (rand_delay()) begin
            @(posedge clk);
            #1;
        end
        bvalid_i = 1'b1;
        @(posedge clk);
        #1;
        bvalid_i = 1'b0;
    endtask

    initial forever serve_read(1'b1);
    initial forever serve_read(1'b0);
    initial forever serve_write();

    // the model executes one instruction per low stall cycle
    initial forever begin
        @(posedge clk);
        #1;
        if (rst_n && !io_stall_o) begin
            compare("fetch count", retired + 1, fetches);
            model_step();
            retired++;
        end
    end

    initial begin
        wait (i_cpu_top.i_cpu_checker.fail_count != 0);
        abort_run("a protocol assertion in the bound checker failed");
    end

    //////////////////////////////////////////////////////////////////////
    // program, stimulus and end of run
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed = 32'h67c4;
        retired = 0;
        fetches = 0;
        model_pc = '0;
        awready_i = 1'b0;
        wready_i = 1'b0;
        bvalid_i = 1'b0;
        arready_inst_i = 1'b0;
        rvalid_inst_i = 1'b0;
        rdata_inst_i = '0;
        arready_data_i = 1'b0;
        rvalid_data_i = 1'b0;
        rdata_data_i = '0;
        for (int i = 0; i < `CPU_REG_N; i++) begin
            model_regs[i] = '0;
        end
        // unused words jump into the final loop
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {cpu_pkg::OP_JUMP, 1'b0, 11'(PROG_LEN), 1'b0};
            mem_data[i] = $random(seed);
            model_dmem[i] = mem_data[i];
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = $random(seed);
            if (imem[i][15:13] == cpu_pkg::OP_JUMP) begin
                imem[i][11:1] = {$random(seed)} % (PROG_LEN + 1);
            end
        end
        @(negedge rst_n);
        @(posedge rst_n);
        compare("io_stall_o", 1'b1, io_stall_o);
        wait (retired >= RETIRE_N);
        if (i_cpu_top.i_cpu_checker.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog, 20 cycles per instruction covers the slowest load
    initial begin
        repeat (RETIRE_N * 20 + 10) @(posedge clk);
        abort_run("timeout: the processor stopped retiring instructions");
    end

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        // reset falls just after time zero so every flop sees its edge
        rst_n_o = 1'b1;
        #1 rst_n_o = 1'b0;
        // release just after a rising edge, like every other input
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

//--- cpu_checker.sv
// AXI and stall protocol assertions
`timescale 1ns/1ps

module cpu_checker (
    input logic clk,
    input logic rst_n,
    input logic io_stall_o,
    input logic arvalid_inst_o,
    input logic arready_inst_i,
    input logic arvalid_data_o,
    input logic arready_data_i,
    input logic awvalid_o,
    input logic awready_i,
    input logic wvalid_o,
    input logic wready_i
);

    // number of assertion failures so far
    int fail_count = 0;

    // a valid stays up until its ready
    a_ar_inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_inst_o && !arready_inst_i |=> arvalid_inst_o)
        else begin
            fail_count++;
            $error("instruction arvalid dropped without arready");
        end
    a_ar_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_data_o && !arready_data_i |=> arvalid_data_o)
        else begin
            fail_count++;
            $error("data arvalid dropped without arready");
        end
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o)
        else begin
            fail_count++;
            $error("awvalid dropped without awready");
        end
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && !wready_i |=> wvalid_o)
        else begin
            fail_count++;
            $error("wvalid dropped without wready");
        end

    // stall is high in reset and in the first cycle after it
    a_stall_reset: assert property (@(posedge clk) !rst_n |-> io_stall_o)
        else begin
            fail_count++;
            $error("io_stall_o low during reset");
        end
    a_stall_first: assert property (@(posedge clk) $rose(rst_n) |=> io_stall_o)
        else begin
            fail_count++;
            $error("io_stall_o low right after reset");
        end

    a_one_reader: assert property (@(posedge clk) disable iff (!rst_n)
        !(arvalid_inst_o && arvalid_data_o))
        else begin
            fail_count++;
            $error("both read address valids high together");
        end

endmodule

bind cpu_top cpu_checker i_cpu_checker (.*);

//--- cpu_top.sv
// processor top level
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   io_stall_o,
    // data write channels
    output logic [`CPU_ADDR_W-1:0] awaddr_o,
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output logic [`CPU_DATA_W-1:0] wdata_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    // instruction read channels
    output logic [`CPU_ADDR_W-1:0] araddr_inst_o,
    output logic                   arvalid_inst_o,
    input  logic                   arready_inst_i,
    input  logic                   rvalid_inst_i,
    input  logic [`CPU_DATA_W-1:0] rdata_inst_i,
    // data read channels
    output logic [`CPU_ADDR_W-1:0] araddr_data_o,
    output logic                   arvalid_data_o,
    input  logic                   arready_data_i,
    input  logic                   rvalid_data_i,
    input  logic [`CPU_DATA_W-1:0] rdata_data_i
);

    cpu_pkg::reg_idx_t             rs_idx;
    cpu_pkg::reg_idx_t             rt_idx;
    cpu_pkg::reg_idx_t             wr_idx;
    logic signed [`CPU_DATA_W-1:0] rs_val;
    logic signed [`CPU_DATA_W-1:0] rt_val;
    logic signed [`CPU_DATA_W-1:0] alu_res;
    logic signed [`CPU_DATA_W-1:0] wr_data;
    logic [1:0]                    alu_op;
    logic signed [4:0]             imm;
    logic                          eq;
    logic                          wr_en;
    logic [`CPU_PC_W-1:0]          eff_addr;

    //////////////////////////////////////////////////////////////////////
    // request buses
    //////////////////////////////////////////////////////////////////////

    mem_req_if #(.HAS_WRITE(1'b0)) if_bus ();
    mem_req_if #(.HAS_WRITE(1'b1)) ds_bus ();

    //////////////////////////////////////////////////////////////////////
    // core
    //////////////////////////////////////////////////////////////////////

    cpu_control i_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_bus     (if_bus.master),
        .ds_bus     (ds_bus.master),
        .rt_val_i   (rt_val),
        .alu_res_i  (alu_res),
        .eq_i       (eq),
        .eff_addr_i (eff_addr),
        .rs_idx_o   (rs_idx),
        .rt_idx_o   (rt_idx),
        .alu_op_o   (alu_op),
        .imm_o      (imm),
        .wr_en_o    (wr_en),
        .wr_idx_o   (wr_idx),
        .wr_data_o  (wr_data),
        .io_stall_o (io_stall_o)
    );

    cpu_regfile i_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs_idx_i  (rs_idx),
        .rt_idx_i  (rt_idx),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data),
        .rs_val_o  (rs_val),
        .rt_val_o  (rt_val)
    );

    cpu_alu i_alu (
        .alu_op_i   (alu_op),
        .rs_val_i   (rs_val),
        .rt_val_i   (rt_val),
        .imm_i      (imm),
        .alu_res_o  (alu_res),
        .eq_o       (eq),
        .eff_addr_o (eff_addr)
    );

    //////////////////////////////////////////////////////////////////////
    // AXI masters
    //////////////////////////////////////////////////////////////////////

    cpu_axi_read_port i_inst_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (if_bus.port),
        .araddr_o  (araddr_inst_o),
        .arvalid_o (arvalid_inst_o),
        .arready_i (arready_inst_i),
        .rvalid_i  (rvalid_inst_i),
        .rdata_i   (rdata_inst_i)
    );

    cpu_axi_read_port i_data_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (ds_bus.port),
        .araddr_o  (araddr_data_o),
        .arvalid_o (arvalid_data_o),
        .arready_i (arready_data_i),
        .rvalid_i  (rvalid_data_i),
        .rdata_i   (rdata_data_i)
    );

    cpu_axi_write_port i_write_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (ds_bus.port),
        .awaddr_o  (awaddr_o),
        .awvalid_o (awvalid_o),
        .wdata_o   (wdata_o),
        .wvalid_o  (wvalid_o),
        .awready_i (awready_i),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i)
    );

endmodule

//--- cpu_control.sv
// processor control unit
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_control (
    input  logic                          clk,
    input  logic                          rst_n,
    mem_req_if.master                     if_bus,
    mem_req_if.master                     ds_bus,
    input  logic signed [`CPU_DATA_W-1:0] rt_val_i,
    input  logic signed [`CPU_DATA_W-1:0] alu_res_i,
    input  logic                          eq_i,
    input  logic [`CPU_PC_W-1:0]          eff_addr_i,
    output cpu_pkg::reg_idx_t             rs_idx_o,
    output cpu_pkg::reg_idx_t             rt_idx_o,
    output logic [1:0]                    alu_op_o,
    output logic signed [4:0]             imm_o,
    output logic                          wr_en_o,
    output cpu_pkg::reg_idx_t             wr_idx_o,
    output logic signed [`CPU_DATA_W-1:0] wr_data_o,
    output logic                          io_stall_o
);

    cpu_pkg::ctrl_state_e state_q;
    cpu_pkg::insn_t       insn_q;
    logic [`CPU_PC_W-1:0] pc_q;
    logic [`CPU_PC_W-1:0] pc_inc;
    logic [`CPU_PC_W-1:0] pc_exec;
    logic                 is_alu;
    logic                 is_mem;
    logic                 retire;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign rs_idx_o = insn_q.rs;
    assign rt_idx_o = insn_q.rt;
    assign imm_o    = $signed(insn_q[4:0]);
    // upper bit picks the mul/slt group, lower bit is func
    assign alu_op_o = {insn_q.op == cpu_pkg::OP_MULSLT, insn_q.func};

    assign is_alu = insn_q.op inside {cpu_pkg::OP_ARITH, cpu_pkg::OP_MULSLT};
    assign is_mem = insn_q.op inside {cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE};

    // instruction fetch request
    assign if_bus.req   = (state_q == cpu_pkg::S_FETCH);
    assign if_bus.we    = 1'b0;
    assign if_bus.addr  = pc_q;
    assign if_bus.wdata = '0;

    // data request, address and store data stay put until done
    assign ds_bus.req   = (state_q == cpu_pkg::S_LOAD) || (state_q == cpu_pkg::S_STORE);
    assign ds_bus.we    = (state_q == cpu_pkg::S_STORE);
    assign ds_bus.addr  = eff_addr_i;
    assign ds_bus.wdata = rt_val_i;

    assign pc_inc = pc_q + 1'b1;

    // branch target is relative to the next pc
    always_comb begin
        pc_exec = pc_inc;
        if (insn_q.op == cpu_pkg::OP_BEQ && eq_i) begin
            pc_exec = pc_inc + {{(`CPU_PC_W-5){imm_o[4]}}, imm_o};
        end else if (insn_q.op == cpu_pkg::OP_JUMP) begin
            pc_exec = insn_q[11:1];
        end
    end

    assign retire = (state_q == cpu_pkg::S_EXEC && !is_mem) ||
                    ((state_q == cpu_pkg::S_LOAD || state_q == cpu_pkg::S_STORE) &&
                     ds_bus.done);

    // writeback: rd for register ops, rt for a loaded word
    always_comb begin
        wr_en_o   = 1'b0;
        wr_idx_o  = insn_q.rd;
        wr_data_o = alu_res_i;
        if (state_q == cpu_pkg::S_EXEC && is_alu) begin
            wr_en_o = 1'b1;
        end else if (state_q == cpu_pkg::S_LOAD && ds_bus.done) begin
            wr_en_o   = 1'b1;
            wr_idx_o  = insn_q.rt;
            wr_data_o = $signed(ds_bus.rdata);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FSM and pc
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= cpu_pkg::S_FETCH;
            pc_q       <= '0;
            io_stall_o <= 1'b1;
        end else begin
            io_stall_o <= !retire;
            case (state_q)
                cpu_pkg::S_FETCH: begin
                    if (if_bus.done) begin
                        state_q <= cpu_pkg::S_EXEC;
                    end
                end
                cpu_pkg::S_EXEC: begin
                    if (insn_q.op == cpu_pkg::OP_LOAD) begin
                        state_q <= cpu_pkg::S_LOAD;
                    end else if (insn_q.op == cpu_pkg::OP_STORE) begin
                        state_q <= cpu_pkg::S_STORE;
                    end else begin
                        state_q <= cpu_pkg::S_FETCH;
                        pc_q    <= pc_exec;
                    end
                end
                default: begin
                    if (ds_bus.done) begin
                        state_q <= cpu_pkg::S_FETCH;
                        pc_q    <= pc_inc;
                    end
                end
            endcase
        end
    end

    // fetched word, held through execute and the data access
    always_ff @(posedge clk) begin
        if (state_q == cpu_pkg::S_FETCH && if_bus.done) begin
            insn_q <= cpu_pkg::insn_t'(if_bus.rdata);
        end
    end

endmodule

//--- cpu_axi_write_port.sv
// single beat AXI4 write master
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_axi_write_port (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_req_if.port                bus,
    output logic [`CPU_ADDR_W-1:0] awaddr_o,
    output logic                   awvalid_o,
    output logic [`CPU_DATA_W-1:0] wdata_o,
    output logic                   wvalid_o,
    input  logic                   awready_i,
    input  logic                   wready_i,
    input  logic                   bvalid_i
);

    logic busy_q;
    logic start;
    logic done;

    assign start = bus.req && bus.we && !busy_q;
    // response only counts after both AW and W went through
    assign done  = busy_q && !awvalid_o && !wvalid_o && bvalid_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
        end else if (start) begin
            busy_q    <= 1'b1;
            awvalid_o <= 1'b1;
            wvalid_o  <= 1'b1;
        end else begin
            // each channel drops on its own handshake
            if (awready_i) begin
                awvalid_o <= 1'b0;
            end
            if (wready_i) begin
                wvalid_o <= 1'b0;
            end
            if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign awaddr_o    = `CPU_MEM_BASE + `CPU_ADDR_W'({bus.addr, 1'b0});
    assign wdata_o     = bus.wdata;
    assign bus.wr_done = done;

endmodule

//--- cpu_axi_read_port.sv
// single beat AXI4 read master
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_axi_read_port (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_req_if.port                bus,
    output logic [`CPU_ADDR_W-1:0] araddr_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    input  logic                   rvalid_i,
    input  logic [`CPU_DATA_W-1:0] rdata_i
);

    logic busy_q;
    logic start;
    logic done;

    // reads only, a write request on a shared bus is ignored
    assign start = bus.req && !bus.we && !busy_q;
    // rready is always high, the beat lands once AR is through
    assign done  = busy_q && !arvalid_o && rvalid_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            arvalid_o <= 1'b0;
        end else if (start) begin
            busy_q    <= 1'b1;
            arvalid_o <= 1'b1;
        end else begin
            if (arvalid_o && arready_i) begin
                arvalid_o <= 1'b0;
            end
            if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign araddr_o    = `CPU_MEM_BASE + `CPU_ADDR_W'({bus.addr, 1'b0});
    assign bus.rdata   = rdata_i;
    assign bus.rd_done = done;

endmodule

//--- cpu_alu.sv
// arithmetic unit
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_alu (
    input  logic [1:0]                    alu_op_i,
    input  logic signed [`CPU_DATA_W-1:0] rs_val_i,
    input  logic signed [`CPU_DATA_W-1:0] rt_val_i,
    input  logic signed [4:0]             imm_i,
    output logic signed [`CPU_DATA_W-1:0] alu_res_o,
    output logic                          eq_o,
    output logic [`CPU_PC_W-1:0]          eff_addr_o
);

    logic signed [2*`CPU_DATA_W-1:0] product;
    logic signed [`CPU_DATA_W-1:0]   addr_sum;

    assign product  = rs_val_i * rt_val_i;
    // imm sign extends against the signed base
    assign addr_sum = rs_val_i + imm_i;

    always_comb begin
        case (alu_op_i)
            2'b00:   alu_res_o = rs_val_i + rt_val_i;
            2'b01:   alu_res_o = rs_val_i - rt_val_i;
            2'b10:   alu_res_o = {{(`CPU_DATA_W-1){1'b0}}, rs_val_i < rt_val_i};
            default: alu_res_o = product[`CPU_DATA_W-1:0];
        endcase
    end

    assign eq_o       = (rs_val_i == rt_val_i);
    assign eff_addr_o = addr_sum[`CPU_PC_W-1:0];

endmodule

//--- cpu_regfile.sv
// general purpose register file
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cpu_pkg::reg_idx_t             rs_idx_i,
    input  cpu_pkg::reg_idx_t             rt_idx_i,
    input  logic                          wr_en_i,
    input  cpu_pkg::reg_idx_t             wr_idx_i,
    input  logic signed [`CPU_DATA_W-1:0] wr_data_i,
    output logic signed [`CPU_DATA_W-1:0] rs_val_o,
    output logic signed [`CPU_DATA_W-1:0] rt_val_o
);

    logic signed [`CPU_DATA_W-1:0] regs_q [`CPU_REG_N];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_N; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    // combinational read ports
    assign rs_val_o = regs_q[rs_idx_i];
    assign rt_val_o = regs_q[rt_idx_i];

endmodule

//--- mem_req_if.sv
// memory request bus
`timescale 1ns/1ps
`include "cpu_defines.svh"

interface mem_req_if #(
    parameter bit HAS_WRITE = 1'b0
);
    logic                   req;
    logic                   we;
    logic [`CPU_PC_W-1:0]   addr;
    logic [`CPU_DATA_W-1:0] wdata;
    logic [`CPU_DATA_W-1:0] rdata;
    logic                   done;
    // completion from the read side and from the write side
    logic                   rd_done;
    logic                   wr_done;

    // no write port on this bus, so no write ever completes
    if (!HAS_WRITE) begin : g_no_write
        assign wr_done = 1'b0;
    end

    assign done = rd_done | wr_done;

    modport master (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport port (
        input  req, we, addr, wdata,
        output rdata, rd_done, wr_done
    );

endinterface

//--- cpu_pkg.sv
// processor types
`include "cpu_defines.svh"

package cpu_pkg;

    // instruction major opcode, top three bits of the word
    typedef enum logic [2:0] {
        OP_ARITH  = 3'd0,
        OP_MULSLT = 3'd1,
        OP_LOAD   = 3'd2,
        OP_STORE  = 3'd3,
        OP_BEQ    = 3'd4,
        OP_JUMP   = 3'd5,
        OP_NOP6   = 3'd6,
        OP_NOP7   = 3'd7
    } opcode_e;

    typedef logic [$clog2(`CPU_REG_N)-1:0] reg_idx_t;

    // rd and func double as the immediate, bits 11..1 as the jump target
    typedef struct packed {
        opcode_e  op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     func;
    } insn_t;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_LOAD,
        S_STORE
    } ctrl_state_e;

endpackage

//--- cpu_defines.svh
// processor shared constants
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// register and memory word width
`define CPU_DATA_W 16

// instruction and data word address width
`define CPU_PC_W 11

// AXI byte address width
`define CPU_ADDR_W 32

// size of the register file
`define CPU_REG_N 16

// byte address of word 0 of the memory region
`define CPU_MEM_BASE 32'h0000_1000

`endif
